// File: hdl/dcache_pkg.sv
package dcache_pkg;

    localparam int addr_w   = 32;   // byte address
    localparam int num_ways = 4;

    typedef logic [1:0] way_t;
    typedef logic [3:0] age_t;      // saturates at 15

    ////////////////////
    // controller and memory op encodings

    typedef enum logic [1:0] {
        st_lookup,
        st_write_back,
        st_refill
    } cache_state_e;

    typedef enum logic {
        op_read,
        op_write
    } mem_op_e;

    ////////////////////
    // request bundles of 70 bits

    typedef struct packed {
        logic              strobe;  // held until p_ready
        logic              write;
        logic [3:0]        wen;
        logic [addr_w-1:0] addr;
        logic [31:0]       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              strobe;  // held until m_ready
        mem_op_e           op;
        logic [3:0]        wen;
        logic [addr_w-1:0] addr;
        logic [31:0]       wdata;
    } mem_req_t;

endpackage

// File: hdl/tag_array.sv
`timescale 1ns/1ns

module tag_array import dcache_pkg::*; #(
    parameter int set_addr_len = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [addr_w-1:0]              addr,
    input  logic                           refill_we,
    input  logic                           hit_we,
    input  way_t                           victim_way,
    output logic                           hit,
    output way_t                           hit_way,
    output logic [num_ways-1:0]            valid_mask,
    output logic                           victim_dirty,
    output logic [addr_w-set_addr_len-3:0] victim_tag
);

    localparam int tag_w  = addr_w - set_addr_len - 2;
    localparam int n_sets = 1 << set_addr_len;

    logic [num_ways-1:0]     valid_q [n_sets];
    logic [num_ways-1:0]     dirty_q [n_sets];
    logic [tag_w-1:0]        tag_q [n_sets][num_ways];
    logic [set_addr_len-1:0] index;
    logic [tag_w-1:0]        tag;
    logic [num_ways-1:0]     match;
    logic                    dup_tag;

    assign index = addr[set_addr_len+1:2];
    assign tag   = addr[addr_w-1:set_addr_len+2];

    // compare all ways, lowest match wins
    always_comb begin
        hit_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            match[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit          = |match;
    assign valid_mask   = valid_q[index];
    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];
    assign victim_tag   = tag_q[index][victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < n_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (refill_we) begin
            valid_q[index][victim_way] <= 1'b1;
            dirty_q[index][victim_way] <= 1'b0;    // fresh line is clean
        end else if (hit_we) begin
            dirty_q[index][hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            tag_q[index][victim_way] <= tag;
        end
    end

    ////////////////////
    // duplicate tag check

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < num_ways; i++) begin
            for (int j = i + 1; j < num_ways; j++) begin
                if (valid_q[index][i] && valid_q[index][j] &&
                    tag_q[index][i] == tag_q[index][j]) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // refill only follows a miss, so a line never lands twice in a set
    a_no_dup_tag: assert property (@(posedge clk) disable iff (rst) !dup_tag)
        else $error("two valid ways share a tag");

endmodule

// File: hdl/data_array.sv
`timescale 1ns/1ns

module data_array import dcache_pkg::*; #(
    parameter int set_addr_len = 4
) (
    input  logic              clk,
    input  logic [addr_w-1:0] addr,
    input  logic              refill_we,
    input  logic              hit_we,
    input  way_t              victim_way,
    input  way_t              hit_way,
    input  logic [3:0]        wen,
    input  logic [31:0]       refill_data,
    input  logic [31:0]       wdata,
    output logic [31:0]       hit_data,
    output logic [31:0]       victim_data
);

    localparam int n_sets = 1 << set_addr_len;

    logic [31:0]             word_q [n_sets][num_ways];
    logic [set_addr_len-1:0] index;

    assign index = addr[set_addr_len+1:2];

    always_ff @(posedge clk) begin
        if (refill_we) begin
            word_q[index][victim_way] <= refill_data;   // whole word
        end else if (hit_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wen[b]) begin
                    word_q[index][hit_way][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign hit_data    = word_q[index][hit_way];
    assign victim_data = word_q[index][victim_way];

endmodule

// File: hdl/way_age_tracker.sv
`timescale 1ns/1ns

module way_age_tracker import dcache_pkg::*; #(
    parameter int set_addr_len = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [addr_w-1:0]   addr,
    input  logic [num_ways-1:0] valid_mask,
    input  logic                refill_we,
    input  logic                touch,
    input  way_t                hit_way,
    output way_t                victim_way
);

    localparam int n_sets = 1 << set_addr_len;

    age_t                    age_q [n_sets][num_ways];
    age_t                    best_age;
    way_t                    acc_way;
    logic [set_addr_len-1:0] index;

    assign index   = addr[set_addr_len+1:2];
    assign acc_way = refill_we ? victim_way : hit_way;

    ////////////////////
    // age update

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < n_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (refill_we || touch) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_t'(w) == acc_way) begin
                    age_q[index][w] <= '0;                      // just used
                end else if (age_q[index][w] != '1) begin
                    age_q[index][w] <= age_q[index][w] + 1'b1;  // saturating
                end
            end
        end
    end

    ////////////////////
    // victim pick

    always_comb begin
        victim_way = '0;
        best_age   = age_q[index][0];
        // oldest way, strict compare keeps the lower number on ties
        for (int w = 1; w < num_ways; w++) begin
            if (age_q[index][w] > best_age) begin
                best_age   = age_q[index][w];
                victim_way = way_t'(w);
            end
        end
        // an empty way beats any age
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

endmodule

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl import dcache_pkg::*; #(
    parameter int set_addr_len = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  cpu_req_t                       cpu_req,
    input  logic                           hit,
    input  logic                           victim_dirty,
    input  logic [addr_w-set_addr_len-3:0] victim_tag,
    input  logic [31:0]                    line_data,   // victim word for write-back
    input  logic [31:0]                    hit_data,
    input  logic [31:0]                    m_dout,
    input  logic                           m_ready,
    output logic                           refill_we,
    output logic                           hit_we,
    output logic [31:0]                    p_din,
    output logic                           p_ready,
    output mem_req_t                       mem_req
);

    localparam int tag_w = addr_w - set_addr_len - 2;

    cache_state_e            state_q;
    cache_state_e            state_d;
    logic                    uncached;
    logic                    cached_req;
    logic [set_addr_len-1:0] index;
    logic [tag_w-1:0]        tag;

    assign uncached   = cpu_req.addr[31:29] == 3'b101;   // bypass window
    assign cached_req = cpu_req.strobe && !uncached;
    assign index      = cpu_req.addr[set_addr_len+1:2];
    assign tag        = cpu_req.addr[addr_w-1:set_addr_len+2];

    assign hit_we    = (state_q == st_lookup) && cached_req && cpu_req.write && hit;
    assign refill_we = (state_q == st_refill) && m_ready;

    // hits answer in the strobe cycle, bypass follows memory
    assign p_ready = uncached ? (cpu_req.strobe && m_ready)
                              : ((state_q == st_lookup) && cached_req && hit);
    assign p_din   = uncached ? m_dout : hit_data;

    ////////////////////
    // miss FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_lookup: begin
                if (cached_req && !hit) begin
                    state_d = victim_dirty ? st_write_back : st_refill;
                end
            end
            st_write_back: begin
                if (m_ready) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                if (m_ready) begin
                    state_d = st_lookup;    // retry, now a hit
                end
            end
            default: state_d = st_lookup;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_lookup;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // memory port mux

    always_comb begin
        mem_req = '0;
        if (state_q == st_write_back) begin
            mem_req.strobe = 1'b1;
            mem_req.op     = op_write;
            mem_req.wen    = 4'hf;
            mem_req.addr   = {victim_tag, index, 2'b00};
            mem_req.wdata  = line_data;
        end else if (state_q == st_refill) begin
            mem_req.strobe = 1'b1;
            mem_req.op     = op_read;
            mem_req.wen    = 4'hf;
            mem_req.addr   = {tag, index, 2'b00};
        end else if (uncached) begin
            mem_req.strobe = cpu_req.strobe;
            mem_req.op     = cpu_req.write ? op_write : op_read;
            mem_req.wen    = cpu_req.wen;
            mem_req.addr   = {3'b000, cpu_req.addr[28:0]};  // physical alias
            mem_req.wdata  = cpu_req.wdata;
        end
    end

    // victim tag and age state must hold while memory stalls
    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req.strobe && !m_ready |=> $stable(mem_req))
        else $error("mem_req changed before m_ready");

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*; #(
    parameter int set_addr_len = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  cpu_req_t    cpu_req,
    output logic [31:0] p_din,
    output logic        p_ready,
    output mem_req_t    mem_req,
    input  logic [31:0] m_dout,
    input  logic        m_ready
);

    localparam int tag_w = addr_w - set_addr_len - 2;

    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic                victim_dirty;
    logic [tag_w-1:0]    victim_tag;
    logic [num_ways-1:0] valid_mask;
    logic                refill_we;
    logic                hit_we;
    logic [31:0]         hit_data;
    logic [31:0]         victim_data;

    dcache_ctrl #(.set_addr_len(set_addr_len)) i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .line_data    (victim_data),
        .hit_data     (hit_data),
        .m_dout       (m_dout),
        .m_ready      (m_ready),
        .refill_we    (refill_we),
        .hit_we       (hit_we),
        .p_din        (p_din),
        .p_ready      (p_ready),
        .mem_req      (mem_req)
    );

    tag_array #(.set_addr_len(set_addr_len)) i_tags (
        .clk          (clk),
        .rst          (rst),
        .addr         (cpu_req.addr),
        .refill_we    (refill_we),
        .hit_we       (hit_we),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .valid_mask   (valid_mask),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_array #(.set_addr_len(set_addr_len)) i_data (
        .clk         (clk),
        .addr        (cpu_req.addr),
        .refill_we   (refill_we),
        .hit_we      (hit_we),
        .victim_way  (victim_way),
        .hit_way     (hit_way),
        .wen         (cpu_req.wen),
        .refill_data (m_dout),       // refill word straight from memory
        .wdata       (cpu_req.wdata),
        .hit_data    (hit_data),
        .victim_data (victim_data)
    );

    way_age_tracker #(.set_addr_len(set_addr_len)) i_age (
        .clk        (clk),
        .rst        (rst),
        .addr       (cpu_req.addr),
        .valid_mask (valid_mask),
        .refill_we  (refill_we),
        .touch      (hit_we),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

endmodule

// File: dv/mem_model.sv
`timescale 1ns/1ns

module mem_model import dcache_pkg::*; #(
    parameter int          delay = 3,       // strobe cycles before m_ready
    parameter logic [31:0] seed  = 32'h1
) (
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    mem_req,
    output logic [31:0] m_dout,
    output logic        m_ready
);

    localparam int depth = 1024;   // words, indexed by addr[11:2]

    logic [31:0] mem [depth];
    logic [9:0]  word;
    int          cnt    = 0;
    logic        loaded = 1'b0;

    assign word    = mem_req.addr[11:2];
    assign m_dout  = mem[word];
    assign m_ready = mem_req.strobe && (cnt == delay);   // one-cycle pulse

    always @(posedge clk) begin
        if (rst) begin
            cnt <= 0;
            // random contents, drawn once on the first reset edge
            if (!loaded) begin
                void'($urandom(seed));
                for (int i = 0; i < depth; i++) begin
                    mem[i] <= $urandom;
                end
                loaded <= 1'b1;
            end
        end else if (m_ready) begin
            cnt <= 0;
            if (mem_req.op == op_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.wen[b]) begin
                        mem[word][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                    end
                end
            end
        end else if (mem_req.strobe) begin
            cnt <= cnt + 1;
        end
    end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb import dcache_pkg::*; ();

    localparam logic [1:0] chk_none  = 2'd0;
    localparam logic [1:0] chk_quiet = 2'd1;   // no memory strobe at all
    localparam logic [1:0] chk_wb    = 2'd2;   // exactly one write, at mem_addr
    localparam logic [1:0] chk_phys  = 2'd3;   // one transfer, at mem_addr
    localparam int         max_wait  = 100;

    typedef struct packed {
        logic [2:0]  id;
        mem_op_e     op;
        logic [3:0]  wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        logic [1:0]  chk;
        logic [31:0] mem_addr;
    } stim_t;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    logic [31:0] p_din;
    logic        p_ready;
    mem_req_t    mem_req;
    logic [31:0] m_dout;
    logic        m_ready;

    stim_t       stim_q [$];
    logic [31:0] shadow [1024];
    int          errors       = 0;
    int          strobe_cnt   = 0;
    int          xfer_cnt     = 0;
    int          wr_cnt       = 0;
    logic [31:0] last_addr    = '0;
    logic [31:0] last_wr_addr = '0;

    dcache_top #(.set_addr_len(4)) i_dut (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .p_din   (p_din),
        .p_ready (p_ready),
        .mem_req (mem_req),
        .m_dout  (m_dout),
        .m_ready (m_ready)
    );

    mem_model #(.delay(3), .seed(32'heac3_1feb)) i_mem (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .m_dout  (m_dout),
        .m_ready (m_ready)
    );

    always #4 clk = ~clk;

    // memory port monitor
    always @(posedge clk) begin
        if (mem_req.strobe) begin
            strobe_cnt <= strobe_cnt + 1;
        end
        if (mem_req.strobe && m_ready) begin
            xfer_cnt  <= xfer_cnt + 1;
            last_addr <= mem_req.addr;
            if (mem_req.op == op_write) begin
                wr_cnt       <= wr_cnt + 1;
                last_wr_addr <= mem_req.addr;
            end
        end
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "cold read";
            3'd2:    return "byte merge";
            3'd3:    return "set conflict";
            3'd4:    return "uncached";
            default: return "repeat hit";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    ////////////////////
    // stimulus table, expected data from the shadow memory

    function automatic void add_write(input logic [2:0] id, input logic [31:0] addr,
                                      input logic [3:0] wen, input logic [31:0] wdata,
                                      input logic [1:0] chk, input logic [31:0] mem_addr);
        stim_t s;
        for (int b = 0; b < 4; b++) begin
            if (wen[b]) begin
                shadow[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];   // byte merge
            end
        end
        s = '{id, op_write, wen, addr, wdata, 32'h0, chk, mem_addr};
        stim_q.push_back(s);
    endfunction

    function automatic void add_read(input logic [2:0] id, input logic [31:0] addr,
                                     input logic [1:0] chk, input logic [31:0] mem_addr);
        stim_t s;
        s = '{id, op_read, 4'hf, addr, 32'h0, shadow[addr[11:2]], chk, mem_addr};
        stim_q.push_back(s);
    endfunction

    function automatic void build_table();
        add_read(3'd1, 32'h0000_0040, chk_none, 32'h0);
        add_write(3'd2, 32'h0000_0084, 4'b0101, 32'haabb_ccdd, chk_none, 32'h0);
        add_read(3'd2, 32'h0000_0084, chk_quiet, 32'h0);
        // set 3 fills ways 0..3, the fifth tag evicts way 0
        for (int t = 1; t <= 4; t++) begin
            add_write(3'd3, 32'h0000_000c | (32'(t) << 8), 4'hf, 32'hc0de_0000 | 32'(t),
                      chk_none, 32'h0);
        end
        add_write(3'd3, 32'h0000_050c, 4'hf, 32'hc0de_0005, chk_wb, 32'h0000_010c);
        for (int t = 1; t <= 5; t++) begin
            add_read(3'd3, 32'h0000_000c | (32'(t) << 8), chk_none, 32'h0);
        end
        add_write(3'd4, 32'ha000_0200, 4'hf, 32'h1234_5678, chk_phys, 32'h0000_0200);
        add_read(3'd4, 32'ha000_0200, chk_phys, 32'h0000_0200);
        add_read(3'd5, 32'h0000_03c8, chk_none, 32'h0);
        add_read(3'd5, 32'h0000_03c8, chk_quiet, 32'h0);
        add_read(3'd5, 32'h0000_03c8, chk_quiet, 32'h0);
    endfunction

    // starts and ends on a falling edge
    task automatic apply(input stim_t s, output bit timed_out);
        int          n;
        int          strobes0;
        int          xfers0;
        int          writes0;
        logic        ready;
        logic [31:0] data;
        string       name;
        name           = test_name(s.id);
        strobes0       = strobe_cnt;
        xfers0         = xfer_cnt;
        writes0        = wr_cnt;
        cpu_req.strobe = 1'b1;
        cpu_req.write  = (s.op == op_write);
        cpu_req.wen    = s.wen;
        cpu_req.addr   = s.addr;
        cpu_req.wdata  = s.wdata;
        n              = 0;
        ready          = 1'b0;
        data           = '0;
        while (!ready && n < max_wait) begin
            @(posedge clk);
            ready = p_ready;
            data  = p_din;
            n++;
        end
        @(negedge clk);
        timed_out = !ready;
        if (timed_out) begin
            errors++;
            $display("timeout: %s access got no p_ready in %0d cycles", name, max_wait);
        end else begin
            if (s.op == op_read) begin
                check_value({name, " data"}, s.exp, data);
            end
            case (s.chk)
                chk_quiet: check_value({name, " strobe cycles"}, 0, strobe_cnt - strobes0);
                chk_wb: begin
                    check_value({name, " write-backs"}, 1, wr_cnt - writes0);
                    check_value({name, " write-back addr"}, s.mem_addr, last_wr_addr);
                end
                chk_phys: begin
                    check_value({name, " transfers"}, 1, xfer_cnt - xfers0);
                    check_value({name, " memory addr"}, s.mem_addr, last_addr);
                end
                default: ;
            endcase
        end
    endtask

    initial begin
        bit timed_out;
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_req   = '0;
        timed_out = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = i_mem.mem[i];   // copy of the initial memory image
        end
        build_table();
        foreach (stim_q[i]) begin
            if (!timed_out) begin
                apply(stim_q[i], timed_out);
            end
        end
        cpu_req.strobe = 1'b0;
        $display("dcache_tb: %0d accesses, %0d errors", stim_q.size(), errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hdl/dcache_pkg.sv
hdl/tag_array.sv
hdl/data_array.sv
hdl/way_age_tracker.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

SRCS := $(wildcard hdl/*.sv dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
